// File: src/ooo_params.svh
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

////////////////////////////////////////////////////////////
// datapath

`define OOO_XLEN 16
`define OOO_NUM_REGS 8

////////////////////////////////////////////////////////////
// window sizes

`define OOO_ROB_DEPTH 8  // keep a power of two, pointers wrap
`define OOO_RS_ENTRIES 4

`endif

// File: src/ooo_pkg.sv
`default_nettype none

`include "ooo_params.svh"

package ooo_pkg;

  typedef logic [`OOO_XLEN-1:0] word_t;
  typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_idx_t;
  typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;  // rename tag = rob slot

  // op[15:12] rd[11:9] rs1[8:6] rs2[5:3], li imm[8:0]
  typedef logic [15:0] inst_t;
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t OP_ADD = 4'd0;
  localparam alu_op_t OP_SUB = 4'd1;
  localparam alu_op_t OP_AND = 4'd2;
  localparam alu_op_t OP_OR = 4'd3;
  localparam alu_op_t OP_XOR = 4'd4;
  localparam alu_op_t OP_SLL = 4'd5;
  localparam alu_op_t OP_LI = 4'd6;
  localparam alu_op_t OP_HALT = 4'd7;  // 8..15 run as add

endpackage

`default_nettype wire

// File: src/dispatch_rename.sv
`default_nettype none

`include "ooo_params.svh"

module dispatch_rename (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        inst_valid,
  input  ooo_pkg::inst_t              inst,
  input  logic [`OOO_RS_ENTRIES-1:0]  rs_busy,
  input  logic                        rob_full,
  input  logic                        halted,
  input  ooo_pkg::rob_tag_t           rob_alloc_tag,
  input  logic                        src1_done,
  input  logic                        src2_done,
  input  ooo_pkg::word_t              src1_data,
  input  ooo_pkg::word_t              src2_data,
  input  logic                        cdb_valid,
  input  ooo_pkg::rob_tag_t           cdb_tag,
  input  ooo_pkg::word_t              cdb_data,
  input  logic                        retire_valid,
  input  ooo_pkg::reg_idx_t           retire_reg,
  input  ooo_pkg::rob_tag_t           retire_tag,
  input  ooo_pkg::word_t              retire_data,
  output logic                        inst_ready,
  output logic                        dispatch_en,
  output ooo_pkg::reg_idx_t           dispatch_rd,
  output logic                        dispatch_done,
  output logic                        dispatch_halt,
  output ooo_pkg::word_t              dispatch_value,
  output ooo_pkg::rob_tag_t           src1_tag,
  output ooo_pkg::rob_tag_t           src2_tag,
  output logic [`OOO_RS_ENTRIES-1:0]  rs_load,
  output ooo_pkg::alu_op_t            rs_op,
  output ooo_pkg::rob_tag_t           rs_tag,
  output ooo_pkg::word_t              rs_val1,
  output ooo_pkg::word_t              rs_val2,
  output logic                        rs_rdy1,
  output logic                        rs_rdy2,
  output ooo_pkg::rob_tag_t           rs_tag1,
  output ooo_pkg::rob_tag_t           rs_tag2
);
  import ooo_pkg::*;

  word_t                     regfile [`OOO_NUM_REGS];
  rob_tag_t                  reg_tag [`OOO_NUM_REGS];
  logic [`OOO_NUM_REGS-1:0]  reg_busy;
  logic                      active;  // low through reset
  alu_op_t                   op;
  reg_idx_t                  rs1, rs2;
  logic                      is_li, is_halt, accept;
  logic [`OOO_RS_ENTRIES-1:0] free_onehot;

  // committed value, then rob, then the bus this cycle
  function automatic void resolve(
    input  logic     busy,
    input  rob_tag_t tag,
    input  word_t    rf_val,
    input  logic     rob_done,
    input  word_t    rob_val,
    output logic     rdy,
    output word_t    val
  );
    rdy = 1'b1;
    val = rf_val;
    if (busy) begin
      if (rob_done) begin
        val = rob_val;
      end else if (cdb_valid && cdb_tag == tag) begin
        val = cdb_data;
      end else begin
        rdy = 1'b0;  // wait on tag
        val = '0;
      end
    end
  endfunction

  assign op      = alu_op_t'(inst[15:12]);
  assign rs1     = inst[8:6];
  assign rs2     = inst[5:3];
  assign is_li   = op == OP_LI;
  assign is_halt = op == OP_HALT;

  always_comb begin
    free_onehot = '0;
    for (int i = `OOO_RS_ENTRIES - 1; i >= 0; i--) begin
      if (!rs_busy[i]) begin
        free_onehot = '0;
        free_onehot[i] = 1'b1;
      end
    end
  end

  assign inst_ready = active && !rob_full && !(&rs_busy) && !halted;
  assign accept     = inst_valid && inst_ready;

  assign dispatch_en    = accept;
  assign dispatch_rd    = inst[11:9];
  assign dispatch_done  = is_li || is_halt;
  assign dispatch_halt  = is_halt;
  assign dispatch_value = is_li ? word_t'(inst[8:0]) : '0;

  assign src1_tag = reg_tag[rs1];
  assign src2_tag = reg_tag[rs2];

  assign rs_load = (accept && !dispatch_done) ? free_onehot : '0;
  assign rs_op   = op;
  assign rs_tag  = rob_alloc_tag;
  assign rs_tag1 = src1_tag;
  assign rs_tag2 = src2_tag;

  always_comb begin
    resolve(reg_busy[rs1], src1_tag, regfile[rs1], src1_done, src1_data, rs_rdy1, rs_val1);
    resolve(reg_busy[rs2], src2_tag, regfile[rs2], src2_done, src2_data, rs_rdy2, rs_val2);
  end

  ////////////////////////////////////////////////////////////
  // register file and status table

  always_ff @(posedge clock) begin
    if (reset) begin
      active   <= 1'b0;
      reg_busy <= '0;
      for (int i = 0; i < `OOO_NUM_REGS; i++) begin
        regfile[i] <= '0;
      end
    end else begin
      active <= 1'b1;
      if (retire_valid) begin
        regfile[retire_reg] <= retire_data;
        if (reg_tag[retire_reg] == retire_tag) begin
          reg_busy[retire_reg] <= 1'b0;  // no younger writer
        end
      end
      // new writer wins over a retire to the same reg
      if (accept && !is_halt) begin
        reg_busy[dispatch_rd] <= 1'b1;
        reg_tag[dispatch_rd]  <= rob_alloc_tag;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/rs_entry.sv
`default_nettype none

module rs_entry (
  input  logic              clock,
  input  logic              reset,
  input  logic              load,
  input  ooo_pkg::alu_op_t  op,
  input  ooo_pkg::rob_tag_t tag,
  input  ooo_pkg::word_t    val1,
  input  ooo_pkg::word_t    val2,
  input  logic              rdy1,
  input  logic              rdy2,
  input  ooo_pkg::rob_tag_t tag1,
  input  ooo_pkg::rob_tag_t tag2,
  input  logic              cdb_valid,
  input  ooo_pkg::rob_tag_t cdb_tag,
  input  ooo_pkg::word_t    cdb_data,
  input  logic              grant,
  output logic              busy,
  output logic              ready,
  output ooo_pkg::alu_op_t  entry_op,
  output ooo_pkg::word_t    entry_val1,
  output ooo_pkg::word_t    entry_val2,
  output ooo_pkg::rob_tag_t entry_tag
);
  import ooo_pkg::*;

  logic     rdy1_q, rdy2_q;
  rob_tag_t tag1_q, tag2_q;
  logic     hit1, hit2;

  // bus snoop for missing operands
  assign hit1 = busy && !rdy1_q && cdb_valid && cdb_tag == tag1_q;
  assign hit2 = busy && !rdy2_q && cdb_valid && cdb_tag == tag2_q;

  assign ready = busy && rdy1_q && rdy2_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (load) begin
      busy <= 1'b1;
    end else if (grant) begin
      busy <= 1'b0;  // off to the alu
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      entry_op   <= op;
      entry_tag  <= tag;
      entry_val1 <= val1;
      entry_val2 <= val2;
      rdy1_q     <= rdy1;
      rdy2_q     <= rdy2;
      tag1_q     <= tag1;
      tag2_q     <= tag2;
    end else begin
      if (hit1) begin
        entry_val1 <= cdb_data;
        rdy1_q     <= 1'b1;
      end
      if (hit2) begin
        entry_val2 <= cdb_data;
        rdy2_q     <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/issue_alu.sv
`default_nettype none

`include "ooo_params.svh"

module issue_alu (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic [`OOO_RS_ENTRIES-1:0]                    slot_ready,
  input  ooo_pkg::alu_op_t  [`OOO_RS_ENTRIES-1:0]       slot_op,
  input  ooo_pkg::word_t    [`OOO_RS_ENTRIES-1:0]       slot_val1,
  input  ooo_pkg::word_t    [`OOO_RS_ENTRIES-1:0]       slot_val2,
  input  ooo_pkg::rob_tag_t [`OOO_RS_ENTRIES-1:0]       slot_tag,
  output logic [`OOO_RS_ENTRIES-1:0]                    grant,
  output logic                                          cdb_valid,
  output ooo_pkg::rob_tag_t                             cdb_tag,
  output ooo_pkg::word_t                                cdb_data
);
  import ooo_pkg::*;

  localparam int N = `OOO_RS_ENTRIES;
  localparam int SEL_W = (N > 1) ? $clog2(N) : 1;

  logic [SEL_W-1:0] sel;
  logic             any_ready;

  // stage 1 operands, stage 2 result
  logic     s1_valid;
  alu_op_t  s1_op;
  word_t    s1_a, s1_b;
  rob_tag_t s1_tag;
  word_t    alu_out;
  logic     s2_valid;
  rob_tag_t s2_tag;
  word_t    s2_data;

  ////////////////////////////////////////////////////////////
  // pick lowest ready slot

  always_comb begin
    sel = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (slot_ready[i]) begin
        sel = SEL_W'(i);
      end
    end
  end

  assign any_ready = |slot_ready;
  assign grant     = any_ready ? (N'(1) << sel) : '0;

  always_comb begin
    case (s1_op)
      OP_ADD:  alu_out = s1_a + s1_b;
      OP_SUB:  alu_out = s1_a - s1_b;
      OP_AND:  alu_out = s1_a & s1_b;
      OP_OR:   alu_out = s1_a | s1_b;
      OP_XOR:  alu_out = s1_a ^ s1_b;
      OP_SLL:  alu_out = s1_a << s1_b[3:0];  // low 4 bits only
      default: alu_out = s1_a + s1_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= any_ready;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clock) begin
    s1_op   <= slot_op[sel];
    s1_a    <= slot_val1[sel];
    s1_b    <= slot_val2[sel];
    s1_tag  <= slot_tag[sel];
    s2_tag  <= s1_tag;
    s2_data <= alu_out;
  end

  assign cdb_valid = s2_valid;
  assign cdb_tag   = s2_tag;
  assign cdb_data  = s2_data;

endmodule

`default_nettype wire

// File: src/rob.sv
`default_nettype none

`include "ooo_params.svh"

module rob (
  input  logic              clock,
  input  logic              reset,
  input  logic              dispatch_en,
  input  ooo_pkg::reg_idx_t dispatch_rd,
  input  logic              dispatch_done,
  input  ooo_pkg::word_t    dispatch_value,
  input  logic              dispatch_halt,
  input  logic              cdb_valid,
  input  ooo_pkg::rob_tag_t cdb_tag,
  input  ooo_pkg::word_t    cdb_data,
  input  ooo_pkg::rob_tag_t src1_tag,
  input  ooo_pkg::rob_tag_t src2_tag,
  output ooo_pkg::rob_tag_t alloc_tag,
  output logic              rob_full,
  output logic              src1_done,
  output logic              src2_done,
  output ooo_pkg::word_t    src1_data,
  output ooo_pkg::word_t    src2_data,
  output logic              retire_valid,
  output ooo_pkg::reg_idx_t retire_reg,
  output ooo_pkg::rob_tag_t retire_tag,
  output ooo_pkg::word_t    retire_data,
  output logic              halted
);
  import ooo_pkg::*;

  localparam int DEPTH = `OOO_ROB_DEPTH;
  localparam int CNT_W = $clog2(DEPTH) + 1;

  logic [DEPTH-1:0] done_q;
  logic [DEPTH-1:0] halt_q;
  reg_idx_t         dest_q [DEPTH];
  word_t            value_q [DEPTH];
  rob_tag_t         head, tail;
  logic [CNT_W-1:0] count;
  logic             retire_fire;  // head leaves, halt or not

  assign alloc_tag = tail;
  assign rob_full  = count == CNT_W'(DEPTH);

  // operand lookup for dispatch
  assign src1_done = done_q[src1_tag];
  assign src2_done = done_q[src2_tag];
  assign src1_data = value_q[src1_tag];
  assign src2_data = value_q[src2_tag];

  assign retire_fire  = count != '0 && done_q[head] && !halted;
  assign retire_valid = retire_fire && !halt_q[head];
  assign retire_reg   = dest_q[head];
  assign retire_tag   = head;
  assign retire_data  = value_q[head];

  ////////////////////////////////////////////////////////////
  // pointers, done bits, halt

  always_ff @(posedge clock) begin
    if (reset) begin
      head   <= '0;
      tail   <= '0;
      count  <= '0;
      done_q <= '0;
      halted <= 1'b0;
    end else begin
      if (cdb_valid) begin
        done_q[cdb_tag] <= 1'b1;
      end
      if (dispatch_en) begin
        done_q[tail] <= dispatch_done;  // li and halt arrive done
        tail         <= tail + 1'b1;
      end
      if (retire_fire) begin
        head <= head + 1'b1;
        if (halt_q[head]) begin
          halted <= 1'b1;
        end
      end
      count <= count + CNT_W'(dispatch_en) - CNT_W'(retire_fire);
    end
  end

  always_ff @(posedge clock) begin
    if (cdb_valid) begin
      value_q[cdb_tag] <= cdb_data;
    end
    if (dispatch_en) begin
      dest_q[tail]  <= dispatch_rd;
      value_q[tail] <= dispatch_value;
      halt_q[tail]  <= dispatch_halt;
    end
  end

endmodule

`default_nettype wire

// File: src/ooo_core.sv
`default_nettype none

`include "ooo_params.svh"

module ooo_core (
  input  logic              clock,
  input  logic              reset,
  input  logic              inst_valid,
  input  ooo_pkg::inst_t    inst,
  output logic              inst_ready,
  output logic              commit_valid,
  output ooo_pkg::reg_idx_t commit_reg,
  output ooo_pkg::word_t    commit_data,
  output logic              halted
);
  import ooo_pkg::*;

  localparam int N = `OOO_RS_ENTRIES;

  // dispatch to rob
  logic     dispatch_en, dispatch_done, dispatch_halt;
  reg_idx_t dispatch_rd;
  word_t    dispatch_value;
  rob_tag_t alloc_tag, src1_tag, src2_tag;
  logic     rob_full, src1_done, src2_done;
  word_t    src1_data, src2_data;

  // slot load bus
  logic [N-1:0] rs_load;
  alu_op_t      rs_op;
  rob_tag_t     rs_tag, rs_tag1, rs_tag2;
  word_t        rs_val1, rs_val2;
  logic         rs_rdy1, rs_rdy2;

  // slot state toward issue
  logic [N-1:0]          slot_busy, slot_ready, issue_grant;
  alu_op_t  [N-1:0]      slot_op;
  word_t    [N-1:0]      slot_val1, slot_val2;
  rob_tag_t [N-1:0]      slot_tag;

  // cdb and retire
  logic     cdb_valid, retire_valid;
  rob_tag_t cdb_tag, retire_tag;
  word_t    cdb_data, retire_data;
  reg_idx_t retire_reg;

  dispatch_rename u_dispatch (
    .clock, .reset, .inst_valid, .inst,
    .rs_busy(slot_busy), .rob_full, .halted, .rob_alloc_tag(alloc_tag),
    .src1_done, .src2_done, .src1_data, .src2_data,
    .cdb_valid, .cdb_tag, .cdb_data,
    .retire_valid, .retire_reg, .retire_tag, .retire_data,
    .inst_ready, .dispatch_en, .dispatch_rd, .dispatch_done, .dispatch_halt,
    .dispatch_value, .src1_tag, .src2_tag,
    .rs_load, .rs_op, .rs_tag, .rs_val1, .rs_val2,
    .rs_rdy1, .rs_rdy2, .rs_tag1, .rs_tag2
  );

  ////////////////////////////////////////////////////////////
  // reservation stations

  for (genvar i = 0; i < N; i++) begin : g_slot
    rs_entry u_slot (
      .clock, .reset,
      .load(rs_load[i]), .op(rs_op), .tag(rs_tag),
      .val1(rs_val1), .val2(rs_val2), .rdy1(rs_rdy1), .rdy2(rs_rdy2),
      .tag1(rs_tag1), .tag2(rs_tag2),
      .cdb_valid, .cdb_tag, .cdb_data,
      .grant(issue_grant[i]),
      .busy(slot_busy[i]), .ready(slot_ready[i]), .entry_op(slot_op[i]),
      .entry_val1(slot_val1[i]), .entry_val2(slot_val2[i]), .entry_tag(slot_tag[i])
    );
  end

  issue_alu u_issue (
    .clock, .reset,
    .slot_ready, .slot_op, .slot_val1, .slot_val2, .slot_tag,
    .grant(issue_grant), .cdb_valid, .cdb_tag, .cdb_data
  );

  rob u_rob (
    .clock, .reset,
    .dispatch_en, .dispatch_rd, .dispatch_done, .dispatch_value, .dispatch_halt,
    .cdb_valid, .cdb_tag, .cdb_data, .src1_tag, .src2_tag,
    .alloc_tag, .rob_full, .src1_done, .src2_done, .src1_data, .src2_data,
    .retire_valid, .retire_reg, .retire_tag, .retire_data, .halted
  );

  assign commit_valid = retire_valid;
  assign commit_reg   = retire_reg;
  assign commit_data  = retire_data;

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;  // period 20
  end

endmodule

`default_nettype wire

// File: dv/ooo_core_tb.sv
`default_nettype none

`include "ooo_params.svh"

module ooo_core_tb;
  import ooo_pkg::*;

  localparam int SEED         = 36233;
  localparam int RESET_CYCLES = 16;
  localparam int RANDOM_LEN   = 240;
  localparam int SEND_TIMEOUT = 200;
  localparam int HALT_TIMEOUT = 2000;
  localparam int QUIET_CYCLES = 50;

  logic     clock;
  logic     reset;
  logic     inst_valid;
  inst_t    inst;
  logic     inst_ready;
  logic     commit_valid;
  reg_idx_t commit_reg;
  word_t    commit_data;
  logic     halted;

  logic [31:0] rng_state;
  word_t       arch_regs [`OOO_NUM_REGS];
  reg_idx_t    exp_reg_q [$];
  word_t       exp_data_q [$];
  int          accept_count;
  int          commit_count;
  int          stall_count;
  logic        halt_sent;

  tb_clock clock_gen (.clock(clock));

  ooo_core dut0 (
    .clock, .reset, .inst_valid, .inst,
    .inst_ready, .commit_valid, .commit_reg, .commit_data, .halted
  );

  ////////////////////////////////////////////////////////////
  // failure reporting and compares

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_reg(input reg_idx_t got, input reg_idx_t want);
    if (got !== want)
      report_error($sformatf("[FAIL] commit_reg got 0x%0h expected 0x%0h", got, want));
  endtask

  task automatic check_word(input word_t got, input word_t want);
    if (got !== want)
      report_error($sformatf("[FAIL] commit_data got 0x%0h expected 0x%0h", got, want));
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus generation

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // mostly r0..r3 so operands collide often
  function automatic reg_idx_t pick_reg(input logic [3:0] bits);
    return bits[3] ? bits[2:0] : {1'b0, bits[1:0]};
  endfunction

  function automatic inst_t make_inst(input logic alu_only);
    logic [31:0] r;
    alu_op_t op;
    r = next_rand();
    op = alu_op_t'(r[3:0]);
    if (op == OP_HALT)
      op = alu_only ? OP_SUB : OP_LI;  // no halt mid-program
    else if (alu_only && op == OP_LI)
      op = OP_XOR;
    if (op == OP_LI)
      return {op, pick_reg(r[7:4]), r[24:16]};
    return {op, pick_reg(r[7:4]), pick_reg(r[11:8]), pick_reg(r[15:12]), r[27:25]};
  endfunction

  ////////////////////////////////////////////////////////////
  // in-order reference model

  function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
    case (op)
      OP_SUB:  return a - b;  // wraps mod 2^16
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[3:0];
      default: return a + b;  // add and spare opcodes
    endcase
  endfunction

  task automatic model_step(input inst_t word);
    alu_op_t op;
    word_t   result;
    op = alu_op_t'(word[15:12]);
    if (op == OP_HALT) begin
      halt_sent = 1'b1;
    end else begin
      if (op == OP_LI)
        result = word_t'(word[8:0]);
      else
        result = alu_model(op, arch_regs[word[8:6]], arch_regs[word[5:3]]);
      arch_regs[word[11:9]] = result;
      exp_reg_q.push_back(word[11:9]);
      exp_data_q.push_back(result);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // per-cycle driving and monitoring

  task automatic watch_outputs();
    reg_idx_t want_reg;
    word_t    want_data;
    if (halted && !halt_sent)
      report_error("halted rose before any HALT was accepted");
    if (halted && exp_reg_q.size() != 0)
      report_error("halted rose while earlier results were still uncommitted");
    if (commit_valid) begin
      if (halted)
        report_error("a commit appeared after the core halted");
      if (exp_reg_q.size() == 0)
        report_error("a commit appeared with no result outstanding");
      want_reg  = exp_reg_q.pop_front();
      want_data = exp_data_q.pop_front();
      check_reg(commit_reg, want_reg);
      check_word(commit_data, want_data);
      commit_count++;
    end
  endtask

  // sampled and driven at the falling edge before the accepting rising edge
  task automatic run_cycle(input logic valid, input inst_t word, output logic taken);
    @(negedge clock);
    watch_outputs();
    inst_valid = valid;
    inst       = word;
    taken      = valid && inst_ready;
    if (valid && !inst_ready)
      stall_count++;
    if (taken) begin
      accept_count++;
      model_step(word);
    end
    if (accept_count - commit_count > `OOO_ROB_DEPTH)
      report_error("more instructions were outstanding than the ROB can hold");
  endtask

  task automatic send_inst(input inst_t word);
    logic taken;
    int   waited;
    taken  = 1'b0;
    waited = 0;
    while (!taken) begin
      if (waited == SEND_TIMEOUT)
        report_error("an instruction was not accepted within the timeout");
      run_cycle(1'b1, word, taken);
      waited++;
    end
  endtask

  task automatic send_program(input int length, input logic gaps, input logic alu_only);
    logic taken;
    for (int n = 0; n < length; n++) begin
      if (gaps && next_rand() % 2 == 0)
        run_cycle(1'b0, '0, taken);  // idle gap
      send_inst(make_inst(alu_only));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    logic taken;
    int   waited;
    int   stalls_before;
    rng_state    = 32'(SEED);
    reset        = 1'b1;
    inst_valid   = 1'b0;
    inst         = '0;
    accept_count = 0;
    commit_count = 0;
    stall_count  = 0;
    halt_sent    = 1'b0;
    for (int r = 0; r < `OOO_NUM_REGS; r++)
      arch_regs[r] = '0;

    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(negedge clock);
      if (inst_ready || commit_valid || halted)
        report_error("an output was active while reset was high");
    end
    reset = 1'b0;

    for (int c = 0; c < 3; c++) begin
      run_cycle(1'b0, '0, taken);
    end

    send_program(4, 1'b0, 1'b1);  // reads of never-written regs
    send_program(RANDOM_LEN, 1'b1, 1'b0);

    // slow dependent chain ahead of a run of LIs fills the ROB
    stalls_before = stall_count;
    send_inst({OP_LI, 3'd5, 9'h0ab});
    for (int k = 0; k < 6; k++)
      send_inst({(k % 2 == 1) ? OP_SUB : OP_ADD, 3'd5, 3'd5, 3'd1, 3'd0});
    for (int k = 0; k < 8; k++)
      send_inst({OP_LI, reg_idx_t'(k), 9'(k * 37 + 300)});
    send_program(12, 1'b0, 1'b0);
    if (stall_count == stalls_before)
      report_error("inst_ready never dropped during the burst");

    send_program(30, 1'b1, 1'b0);

    send_inst({OP_HALT, 12'h000});
    waited = 0;
    while (!halted) begin
      if (waited == HALT_TIMEOUT)
        report_error("halted did not rise after the HALT was accepted");
      run_cycle(1'b0, '0, taken);
      waited++;
    end

    // halted core must ignore further traffic
    for (int c = 0; c < QUIET_CYCLES; c++) begin
      run_cycle(1'b1, make_inst(1'b0), taken);
      if (taken)
        report_error("an instruction was accepted after the core halted");
      if (!halted)
        report_error("halted fell again without a reset");
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+src
src/ooo_pkg.sv
src/dispatch_rename.sv
src/rs_entry.sv
src/issue_alu.sv
src/rob.sv
src/ooo_core.sv
dv/tb_clock.sv
dv/ooo_core_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module ooo_core_tb \
  -Mdir obj_dir -o sim \
  && ./obj_dir/sim 2>&1 | tee sim.log \
  || { echo "build or simulation did not run"; exit 1; }

test -s sim.log || { echo "no simulation log"; exit 1; }
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0
